//--- design/bch_pkg.sv
`default_nettype none

package bch_pkg;

    // ------------------------------------------------------------
    // code sizes
    // ------------------------------------------------------------
    localparam int code_len   = 15;           // codeword length n
    localparam int msg_len    = 5;            // message length k
    localparam int gf_width   = 4;            // bits per GF(16) element
    localparam int num_syn    = 6;            // 2*t syndromes
    localparam int max_errors = 3;            // t, most errors we inject

    // ------------------------------------------------------------
    // field constants
    // ------------------------------------------------------------
    // generator g(x) of the t=3 code, degree n-k
    localparam logic [code_len-msg_len:0] gen_poly = 11'b10100110111;

    // x^4 + x + 1
    localparam logic [gf_width:0] prim_poly = 5'b10011;

    // ------------------------------------------------------------
    // types
    // ------------------------------------------------------------
    typedef logic [msg_len-1:0]  message_t;
    typedef logic [code_len-1:0] codeword_t;   // also the received word
    typedef logic [gf_width-1:0] gf_elem_t;

    // element 0 holds S1, element 5 holds S6
    typedef gf_elem_t [num_syn-1:0] syndrome_arr_t;

    typedef logic [$clog2(max_errors+1)-1:0] err_count_t;
    typedef logic [$clog2(code_len+1)-1:0]   step_t;   // counter value and bit index

    // controller phases
    typedef enum logic [2:0] {
        idle     = 3'h0,
        encode   = 3'h1,
        inject   = 3'h2,
        syndrome = 3'h3,
        finish   = 3'h4
    } bch_state_e;

endpackage

`default_nettype wire

//--- design/bch_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface bch_ctrl_if;

    logic               encode_en;    // single cycle
    logic               inject_load;  // first cycle of inject
    logic               inject_en;    // level while flipping
    logic               flip_done;    // one pulse per accepted flip
    logic               syndrome_en;  // level during the 15 steps
    logic               count_clear;
    bch_pkg::step_t     count_limit;
    bch_pkg::step_t     count;        // doubles as the syndrome bit index
    logic               count_hit;

    modport ctrl (
        output encode_en, inject_load, inject_en, syndrome_en,
        output count_clear, count_limit,
        input  flip_done, count_hit
    );

    modport counter (
        input  count_clear, count_limit, flip_done, syndrome_en,
        output count, count_hit
    );

    modport encoder (input encode_en);

    modport injector (
        input  inject_load, inject_en,
        output flip_done
    );

    modport syndrome (input syndrome_en, count_clear, count);

endinterface

`default_nettype wire

//--- design/bch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module bch_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  bch_pkg::err_count_t num_errors,
    output logic                busy,
    output logic                done,
    bch_ctrl_if.ctrl            bus
);

    bch_pkg::bch_state_e state;
    bch_pkg::bch_state_e state_nxt;
    bch_pkg::err_count_t err_q;     // errors requested at start
    logic                load_q;    // marks the first inject cycle

    // ------------------------------------------------------------
    // state and latched request
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state  <= bch_pkg::idle;
            err_q  <= '0;
            load_q <= 1'b0;
        end
        else
        begin
            state  <= state_nxt;
            load_q <= (state == bch_pkg::encode);
            if (state == bch_pkg::idle && start)
            begin
                err_q <= num_errors;
            end
        end
    end

    // ------------------------------------------------------------
    // next state and phase enables
    // ------------------------------------------------------------
    always_comb
    begin
        state_nxt       = state;
        bus.encode_en   = 1'b0;
        bus.inject_load = 1'b0;
        bus.inject_en   = 1'b0;
        bus.syndrome_en = 1'b0;
        bus.count_clear = 1'b0;
        case (state)
            bch_pkg::idle:
            begin
                if (start)
                begin
                    state_nxt = bch_pkg::encode;
                end
            end
            bch_pkg::encode:
            begin
                bus.encode_en = 1'b1;
                state_nxt     = bch_pkg::inject;
            end
            bch_pkg::inject:
            begin
                if (load_q)
                begin
                    bus.inject_load = 1'b1;
                    bus.count_clear = 1'b1;       // flips count from zero
                    if (err_q == '0)
                    begin
                        state_nxt = bch_pkg::syndrome;  // nothing to flip
                    end
                end
                else
                begin
                    bus.inject_en = 1'b1;
                    if (bus.count_hit)            // last flip lands this cycle
                    begin
                        bus.count_clear = 1'b1;
                        state_nxt       = bch_pkg::syndrome;
                    end
                end
            end
            bch_pkg::syndrome:
            begin
                bus.syndrome_en = 1'b1;
                if (bus.count_hit)
                begin
                    state_nxt = bch_pkg::finish;
                end
            end
            bch_pkg::finish:  state_nxt = bch_pkg::idle;
            default:          state_nxt = bch_pkg::idle;
        endcase
    end

    assign bus.count_limit = (state == bch_pkg::syndrome) ?
                             bch_pkg::step_t'(bch_pkg::code_len) :
                             bch_pkg::step_t'(err_q);

    assign busy = (state != bch_pkg::idle);
    assign done = (state == bch_pkg::finish);

endmodule

`default_nettype wire

//--- design/step_counter.sv
`timescale 1ns/1ps
`default_nettype none

module step_counter (
    input  logic        clk,
    input  logic        rst,
    bch_ctrl_if.counter bus
);

    logic           step;
    bch_pkg::step_t stepped;

    // a flip or a syndrome cycle both advance the count
    assign step    = bus.flip_done | bus.syndrome_en;
    assign stepped = bus.count + bch_pkg::step_t'(step);

    // hit on the step that brings the count to the limit
    assign bus.count_hit = step && (stepped == bus.count_limit);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            bus.count <= '0;
        end
        else if (bus.count_clear)     // clear wins over a step
        begin
            bus.count <= '0;
        end
        else if (step)
        begin
            bus.count <= stepped;
        end
    end

endmodule

`default_nettype wire

//--- design/bch_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module bch_encoder (
    input  logic               clk,
    input  logic               rst,
    input  bch_pkg::message_t  message,
    output bch_pkg::codeword_t codeword,
    bch_ctrl_if.encoder        bus
);

    // m(x) * g(x) over GF(2)
    function automatic bch_pkg::codeword_t gf2_mul(input bch_pkg::message_t m);
        bch_pkg::codeword_t prod;
        prod = '0;
        for (int i = 0; i < bch_pkg::msg_len; i++)
        begin
            if (m[i])
            begin
                prod = prod ^ (bch_pkg::codeword_t'(bch_pkg::gen_poly) << i);
            end
        end
        return prod;
    endfunction

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            codeword <= '0;
        end
        else if (bus.encode_en)
        begin
            codeword <= gf2_mul(message);   // ready on the next cycle
        end
    end

endmodule

`default_nettype wire

//--- design/error_injector.sv
`timescale 1ns/1ps
`default_nettype none

module error_injector #(
    parameter logic [15:0] lfsr_seed = 16'hace1
) (
    input  logic               clk,
    input  logic               rst,
    input  bch_pkg::codeword_t codeword,
    output bch_pkg::codeword_t received,
    bch_ctrl_if.injector       bus
);

    logic [15:0]        lfsr;
    logic [15:0]        lfsr_nxt;
    logic [3:0]         cand;        // candidate bit position
    bch_pkg::codeword_t cand_sel;    // one-hot of the candidate
    bch_pkg::codeword_t flip_mask;   // positions already flipped
    logic               cand_ok;

    // ------------------------------------------------------------
    // position generator
    // ------------------------------------------------------------
    // galois form, taps 16 14 13 11
    assign lfsr_nxt = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            lfsr <= lfsr_seed;
        end
        else if (bus.inject_en)
        begin
            lfsr <= lfsr_nxt;
        end
    end

    assign cand     = lfsr[3:0];
    assign cand_sel = bch_pkg::codeword_t'(1) << cand;

    // index 15 falls outside the word and a repeat would undo a flip
    assign cand_ok = (cand < 4'(bch_pkg::code_len)) && ((flip_mask & cand_sel) == '0);

    assign bus.flip_done = bus.inject_en && cand_ok;

    // ------------------------------------------------------------
    // received word and flip mask
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            received  <= '0;
            flip_mask <= '0;
        end
        else if (bus.inject_load)
        begin
            received  <= codeword;   // fresh copy for this run
            flip_mask <= '0;
        end
        else if (bus.flip_done)
        begin
            received  <= received ^ cand_sel;
            flip_mask <= flip_mask | cand_sel;
        end
    end

endmodule

`default_nettype wire

//--- design/syndrome_unit.sv
`timescale 1ns/1ps
`default_nettype none

module syndrome_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  bch_pkg::codeword_t     received,
    output bch_pkg::syndrome_arr_t syndromes,
    output logic                   error_detected,
    bch_ctrl_if.syndrome           bus
);

    bch_pkg::step_t bit_idx;
    logic           rx_bit;

    // x * alpha^p, one reduction by prim_poly per power
    function automatic bch_pkg::gf_elem_t mul_alpha_pow(
        input bch_pkg::gf_elem_t x,
        input int                p
    );
        bch_pkg::gf_elem_t acc;
        acc = x;
        for (int k = 0; k < p; k++)
        begin
            acc = {acc[bch_pkg::gf_width-2:0], 1'b0} ^
                  (acc[bch_pkg::gf_width-1] ? bch_pkg::prim_poly[bch_pkg::gf_width-1:0] : '0);
        end
        return acc;
    endfunction

    // MSB first, step 0 reads r14
    assign bit_idx = bch_pkg::step_t'(bch_pkg::code_len - 1) - bus.count;
    assign rx_bit  = received[bit_idx];

    // ------------------------------------------------------------
    // Horner accumulators, Sj = r(alpha^j)
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            syndromes <= '0;
        end
        else if (bus.count_clear)
        begin
            syndromes <= '0;
        end
        else if (bus.syndrome_en)
        begin
            for (int j = 0; j < bch_pkg::num_syn; j++)
            begin
                syndromes[j] <= mul_alpha_pow(syndromes[j], j + 1) ^
                                bch_pkg::gf_elem_t'(rx_bit);
            end
        end
    end

    assign error_detected = |syndromes;   // any nonzero Sj

endmodule

`default_nettype wire

//--- design/bch_codec_top.sv
`timescale 1ns/1ps
`default_nettype none

module bch_codec_top #(
    parameter logic [15:0] lfsr_seed = 16'hace1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  bch_pkg::message_t      message,
    input  bch_pkg::err_count_t    num_errors,
    output logic                   busy,
    output logic                   done,
    output bch_pkg::codeword_t     codeword,
    output bch_pkg::codeword_t     received,
    output bch_pkg::syndrome_arr_t syndromes,
    output logic                   error_detected
);

    bch_ctrl_if ctrl_bus ();

    // ------------------------------------------------------------
    // control path
    // ------------------------------------------------------------
    bch_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .num_errors (num_errors),
        .busy       (busy),
        .done       (done),
        .bus        (ctrl_bus.ctrl)
    );

    step_counter u_counter (
        .clk (clk),
        .rst (rst),
        .bus (ctrl_bus.counter)
    );

    // ------------------------------------------------------------
    // data path: encode -> inject -> syndromes
    // ------------------------------------------------------------
    bch_encoder u_encoder (
        .clk      (clk),
        .rst      (rst),
        .message  (message),
        .codeword (codeword),
        .bus      (ctrl_bus.encoder)
    );

    error_injector #(
        .lfsr_seed (lfsr_seed)
    ) u_injector (
        .clk      (clk),
        .rst      (rst),
        .codeword (codeword),
        .received (received),
        .bus      (ctrl_bus.injector)
    );

    syndrome_unit u_syndrome (
        .clk            (clk),
        .rst            (rst),
        .received       (received),
        .syndromes      (syndromes),
        .error_detected (error_detected),
        .bus            (ctrl_bus.syndrome)
    );

endmodule

`default_nettype wire

//--- verif/bch_codec_sva.sv
`timescale 1ns/1ps
`default_nettype none

module bch_ctrl_sva (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic                done,
    input  bch_pkg::bch_state_e state
);

    logic        in_syn;
    int unsigned sva_failures = 0;   // read by the testbench summary

    assign in_syn = (state == bch_pkg::syndrome);

    // ------------------------------------------------------------
    // controller properties
    // ------------------------------------------------------------
    done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else
        begin
            sva_failures++;
            $error("done held high for more than one cycle");
        end

    // the run ends in idle, so a start seen with done is never taken
    done_no_accept: assert property (@(posedge clk) disable iff (rst)
        done |=> state == bch_pkg::idle)
        else
        begin
            sva_failures++;
            $error("controller left the done cycle somewhere other than idle");
        end

    syn_len: assert property (@(posedge clk) disable iff (rst)
        $rose(in_syn) |-> in_syn [*15] ##1 !in_syn)
        else
        begin
            sva_failures++;
            $error("syndrome phase did not last 15 cycles");
        end

    idle_after_reset: assert property (@(posedge clk) $fell(rst) |-> state == bch_pkg::idle)
        else
        begin
            sva_failures++;
            $error("state not idle after reset");
        end

endmodule

bind bch_ctrl bch_ctrl_sva ctrl_sva0 (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .done  (done),
    .state (state)
);

`default_nettype wire

//--- verif/bch_codec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bch_codec_tb;

    localparam int timeout_cycles = 400;   // inject may spin on rejected candidates
    localparam int runs_per_count = 8;

    logic                   clk;
    logic                   rst;
    logic                   start;
    bch_pkg::message_t      message;
    bch_pkg::err_count_t    num_errors;
    logic                   busy;
    logic                   done;
    bch_pkg::codeword_t     codeword;
    bch_pkg::codeword_t     received;
    bch_pkg::syndrome_arr_t syndromes;
    logic                   error_detected;

    bch_pkg::message_t   exp_msg;          // request of the run in flight
    bch_pkg::err_count_t exp_nerr;
    int                  seed;
    int                  errors;
    int                  checks;
    int                  tests;
    int                  done_count;       // done pulses seen since reset
    bit                  timed_out;

    bch_codec_top #(
        .lfsr_seed (16'hace1)
    ) dut0 (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .message        (message),
        .num_errors     (num_errors),
        .busy           (busy),
        .done           (done),
        .codeword       (codeword),
        .received       (received),
        .syndromes      (syndromes),
        .error_detected (error_detected)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic bch_pkg::codeword_t encode_ref(input bch_pkg::message_t m);
        bch_pkg::codeword_t acc;
        acc = '0;
        for (int i = 0; i < bch_pkg::msg_len; i++)
        begin
            for (int k = 0; k <= bch_pkg::code_len - bch_pkg::msg_len; k++)
            begin
                if (m[i] && bch_pkg::gen_poly[k])
                begin
                    acc[i + k] = ~acc[i + k];   // x^i * x^k term
                end
            end
        end
        return acc;
    endfunction

    function automatic bch_pkg::gf_elem_t alpha_pow(input int e);
        bch_pkg::gf_elem_t a;
        a = 4'h1;
        for (int k = 0; k < e % 15; k++)
        begin
            a = a[3] ? ({a[2:0], 1'b0} ^ 4'h3) : {a[2:0], 1'b0};   // x^4 = x + 1
        end
        return a;
    endfunction

    // Sj = sum of r_i * alpha^(i*j), evaluated term by term
    function automatic bch_pkg::syndrome_arr_t syndromes_ref(input bch_pkg::codeword_t r);
        bch_pkg::syndrome_arr_t s;
        s = '0;
        for (int j = 0; j < bch_pkg::num_syn; j++)
        begin
            for (int i = 0; i < bch_pkg::code_len; i++)
            begin
                if (r[i])
                begin
                    s[j] = s[j] ^ alpha_pow(i * (j + 1));
                end
            end
        end
        return s;
    endfunction

    function automatic int count_ones(input bch_pkg::codeword_t w);
        int n;
        n = 0;
        for (int i = 0; i < bch_pkg::code_len; i++)
        begin
            n = n + w[i];
        end
        return n;
    endfunction

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic check_codeword(input string name, input bch_pkg::codeword_t got,
                                  input bch_pkg::codeword_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_syndromes(input string name, input bch_pkg::syndrome_arr_t got,
                                   input bch_pkg::syndrome_arr_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp)
        begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    // outputs are stable at the falling edge of the done cycle
    always @(negedge clk)
    begin
        if (!rst && done)
        begin
            done_count++;
            check_codeword("codeword", codeword, encode_ref(exp_msg));
            check_count("received^codeword weight", count_ones(received ^ codeword),
                        int'(exp_nerr));
            check_syndromes("syndromes", syndromes, syndromes_ref(received));
            if (exp_nerr == '0)
            begin
                check_syndromes("syndromes", syndromes, bch_pkg::syndrome_arr_t'(0));
            end
            check_flag("error_detected", error_detected, exp_nerr != '0);
        end
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    task automatic wait_done(input int target);
        int cycles;
        cycles = 0;
        while (done_count < target && cycles < timeout_cycles)
        begin
            @(negedge clk);
            cycles++;
        end
        if (done_count < target)
        begin
            errors++;
            timed_out = 1'b1;
            $display("done never arrived within %0d cycles after start", timeout_cycles);
        end
    endtask

    task automatic launch(input bch_pkg::message_t msg, input bch_pkg::err_count_t nerr);
        @(negedge clk);
        message    = msg;
        num_errors = nerr;
        exp_msg    = msg;
        exp_nerr   = nerr;
        start      = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_flag("busy", busy, 1'b1);   // high from the cycle after start
    endtask

    task automatic run_case(input bch_pkg::message_t msg, input bch_pkg::err_count_t nerr);
        int target;
        int errs_before;
        target      = done_count + 1;
        errs_before = errors;
        launch(msg, nerr);
        wait_done(target);
        tests++;
        $display("test %0d msg=%h errors=%0d received=%h %s", tests, msg, nerr, received,
                 (errors == errs_before) ? "ok" : "mismatch");
    endtask

    task automatic retrigger_case();
        int target;
        int errs_before;
        target      = done_count + 1;
        errs_before = errors;
        launch(5'h15, 2'd2);
        repeat (2) @(negedge clk);
        check_flag("busy", busy, 1'b1);
        start = 1'b1;                     // lands mid-run, must be ignored
        @(negedge clk);
        start = 1'b0;
        wait_done(target);
        repeat (40) @(negedge clk);       // window where a second done would show
        check_count("done pulses", done_count, target);
        check_flag("busy", busy, 1'b0);
        tests++;
        $display("test %0d start while busy %s", tests,
                 (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial
    begin
        int sva_fails;
        seed       = 32'h854d2237;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        done_count = 0;
        timed_out  = 1'b0;
        rst        = 1'b1;
        start      = 1'b0;
        message    = '0;
        num_errors = '0;
        exp_msg    = '0;
        exp_nerr   = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        tests++;
        $display("test %0d reset state %s", tests, (errors == 0) ? "ok" : "mismatch");

        // every message, clean channel
        for (int m = 0; m < 32 && !timed_out; m++)
        begin
            run_case(bch_pkg::message_t'(m), '0);
        end
        for (int n = 1; n <= bch_pkg::max_errors && !timed_out; n++)
        begin
            for (int k = 0; k < runs_per_count && !timed_out; k++)
            begin
                run_case(bch_pkg::message_t'($random(seed)), bch_pkg::err_count_t'(n));
            end
        end
        if (!timed_out)
        begin
            retrigger_case();
        end

        sva_fails = dut0.u_ctrl.ctrl_sva0.sva_failures;
        errors    = errors + sva_fails;
        $display("tests=%0d checks=%0d assertion_failures=%0d errors=%0d",
                 tests, checks, sva_fails, errors);
        if (errors == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
design/bch_pkg.sv
design/bch_ctrl_if.sv
design/bch_ctrl.sv
design/step_counter.sv
design/bch_encoder.sv
design/error_injector.sv
design/syndrome_unit.sv
design/bch_codec_top.sv
verif/bch_codec_sva.sv
verif/bch_codec_tb.sv

//--- Bender.yml
package:
  name: bch_codec

sources:
  - design/bch_pkg.sv
  - design/bch_ctrl_if.sv
  - design/bch_ctrl.sv
  - design/step_counter.sv
  - design/bch_encoder.sv
  - design/error_injector.sv
  - design/syndrome_unit.sv
  - design/bch_codec_top.sv
  - target: test
    files:
      - verif/bch_codec_sva.sv
      - verif/bch_codec_tb.sv
